//--- mem_stage_tests.txt
# R reg1 reg2 reg3 reg4 imm seg eip | T idx vpn pfn valid rw | W phys_addr data size
# I name valid size addr addr_end rw seg_lim op1s op2s dsel id ie iet op1 op2 dest type ie iet bp
R 1111111111111111 2222222222222222 3333333333333333 4444444444444444 deadbeef 0abc 00401000
I nomap 1 2 00010000 00010003 1 fffff 0 1 1 2 0 0 1111111111111111 2222222222222222 2 1 1 2 0
T 0 00010 00003 1 1
T 1 00020 00005 1 0
W 00003010 8877665544332211 3
W 00003018 00000000000000aa 0
W 0000301b 000000000000beef 1
W 00005008 0000000000cafe01 2
I sel_a 1 0 0 0 0 fffff 0 1 0 0 0 0 1111111111111111 2222222222222222 0 0 0 0 0
I sel_b 1 0 0 0 0 fffff 2 3 1 3 0 0 3333333333333333 4444444444444444 3 1 0 0 0
I sel_c 1 0 0 0 0 fffff 4 6 2 6 0 0 abc deadbeef 6 2 0 0 0
I sel_d 1 0 00010abc 00010abc 0 fffff 7 0 3 0 0 0 401000 1111111111111111 3abc 4 0 0 0
I ld_q 1 3 00010010 00010017 1 fffff 5 0 1 5 0 0 8877665544332211 1111111111111111 5 1 0 0 0
I ld_b3 1 0 00010013 00010013 1 fffff 5 0 1 5 0 0 44 1111111111111111 5 1 0 0 0
I ld_w2 1 1 00010012 00010013 1 fffff 5 0 1 5 0 0 4433 1111111111111111 5 1 0 0 0
I ld_d4 1 2 00010014 00010017 1 fffff 5 0 1 5 0 0 88776655 1111111111111111 5 1 0 0 0
I ld_d1 1 2 00010011 00010014 1 fffff 5 0 1 5 0 0 55443322 1111111111111111 5 1 0 0 0
I ld_wb 1 1 0001001b 0001001c 1 fffff 5 0 1 5 0 0 beef 1111111111111111 5 1 0 0 0
I ld_ba 1 0 00010018 00010018 1 fffff 5 0 1 5 0 0 aa 1111111111111111 5 1 0 0 0
I ld_ro 1 2 00020008 0002000b 1 fffff 5 6 1 4 0 0 cafe01 deadbeef 4 1 0 0 0
I f_seg 1 3 00010ff0 00010ff7 1 00010 0 1 1 1 0 0 1111111111111111 2222222222222222 1 1 1 1 0
I f_wprot 1 2 00020000 00020003 2 fffff 0 1 3 0 0 0 1111111111111111 2222222222222222 5000 4 1 1 0
I f_pass 1 0 0 0 0 fffff 0 1 0 0 1 c 1111111111111111 2222222222222222 0 0 1 c 0
I f_novalid 0 0 0 0 0 fffff 0 1 0 0 0 0 0 0 0 0 0 0 0
I bp_ld 1 3 00010010 00010017 1 fffff 5 1 1 7 0 0 8877665544332211 2222222222222222 7 1 0 0 1
I bp_nl 1 0 0 0 0 fffff 4 7 2 1 0 0 abc 401000 1 2 0 0 1
I bp_ld2 1 0 00010017 00010017 1 fffff 5 3 1 2 0 0 88 4444444444444444 2 1 0 0 1
I bp_f 1 2 00020000 00020003 2 fffff 2 1 3 0 0 8 3333333333333333 2222222222222222 5000 4 1 9 1
I bp_pg 1 2 00030000 00030003 1 fffff 6 0 1 4 0 0 deadbeef 1111111111111111 4 1 1 2 1

//--- build.f
mem_pkg.sv
tlb_entries.sv
tlb_lookup.sv
fault_detect.sv
data_port.sv
operand_select.sv
stage_reg.sv
mem_stage.sv
tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the memory stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wall -f build.f --top-module tb_mem_stage -o sim_mem_stage
./obj_dir/sim_mem_stage | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb_mem_stage.sv
module tb_mem_stage;
    import mem_pkg::*;

    timeunit 1ns;
    timeprecision 100ps;

    logic clk, rst, valid_in, fwd_stall, ie_in;
    opsize_t opsize, wb_size;
    addr_t mem_addr, mem_addr_end, eip, wb_addr, dest_addr;
    mem_rw_t mem_rw;
    page_t seg_lim, tlb_wr_vpn, tlb_wr_pfn;
    data_t reg1, reg2, reg3, reg4, imm, wb_data, op1_val, op2_val;
    seg_t seg;
    op_sel_e op1_sel, op2_sel;
    dest_sel_e dest_sel;
    logic [2:0] dest_id, tlb_wr_index;
    ie_type_t ie_type_in, ie_type_out;
    logic tlb_wr, tlb_wr_valid, tlb_wr_rw, wb_valid;
    logic valid_out, stall, dest_is_reg, dest_is_seg, dest_is_mem, ie_out;

    int value_errors = 0;
    int other_errors = 0;
    time deadline = 0;
    logic done = 1'b0;
    logic exp_vo = 1'b0;
    data_t last_op1, last_op2;
    addr_t last_dest;
    logic [2:0] last_type;
    logic last_ie;
    ie_type_t last_iet;

    mem_stage #(.TLB_ENTRIES(8), .MEM_WORDS(256)) i_mem_stage (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(string name, string what, logic [63:0] exp, logic [63:0] act);
        $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
        value_errors++;
    endtask

    task automatic idle_cycle();
        fwd_stall = 1'b0;
        @(negedge clk);
        exp_vo = 1'b0;
        tlb_wr = 1'b0;
        wb_valid = 1'b0;
    endtask

    // Outputs of the last accepted instruction must not move under fwd_stall.
    task automatic check_held_outputs(string name);
        if (op1_val !== last_op1) report_mismatch(name, "held op1", last_op1, op1_val);
        if (op2_val !== last_op2) report_mismatch(name, "held op2", last_op2, op2_val);
        if (dest_addr !== last_dest)
            report_mismatch(name, "held dest", 64'(last_dest), 64'(dest_addr));
        if ({dest_is_mem, dest_is_seg, dest_is_reg} !== last_type)
            report_mismatch(name, "held dest type", 64'(last_type),
                64'({dest_is_mem, dest_is_seg, dest_is_reg}));
        if (ie_out !== last_ie) report_mismatch(name, "held ie_out", 64'(last_ie), 64'(ie_out));
        if (ie_type_out !== last_iet)
            report_mismatch(name, "held ie_type", 64'(last_iet), 64'(ie_type_out));
    endtask

    // One instruction line. Inputs stay put until an accepting edge.
    task automatic run_instr(string name, logic [63:0] f [19]);
        logic first;
        logic accepted;
        logic took;
        logic clean;
        logic held;
        valid_in = f[0][0];
        opsize = opsize_t'(f[1]);
        mem_addr = addr_t'(f[2]);
        mem_addr_end = addr_t'(f[3]);
        mem_rw = mem_rw_t'(f[4]);
        seg_lim = page_t'(f[5]);
        op1_sel = op_sel_e'(f[6][2:0]);
        op2_sel = op_sel_e'(f[7][2:0]);
        dest_sel = dest_sel_e'(f[8][1:0]);
        dest_id = f[9][2:0];
        ie_in = f[10][0];
        ie_type_in = ie_type_t'(f[11]);
        clean = f[0][0] && f[4][0] && (f[17][1:0] == 2'b00);   // Load with no new fault.
        first = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            fwd_stall = f[18][0] ? 1'($urandom % 2) : 1'b0;
            #1;
            if (stall !== (fwd_stall || (first && clean)))
                report_mismatch(name, "stall", 64'(fwd_stall || (first && clean)), 64'(stall));
            took = valid_in && !stall;              // Taken at the coming edge.
            accepted = took || !valid_in;
            held = fwd_stall;
            @(negedge clk);
            if (took) exp_vo = 1'b1;
            else if (!held) exp_vo = 1'b0;
            if (valid_out !== exp_vo)
                report_mismatch(name, "valid_out", 64'(exp_vo), 64'(valid_out));
            if (held && exp_vo) check_held_outputs(name);
            first = 1'b0;
        end
        if (valid_in) begin
            if (op1_val !== f[12]) report_mismatch(name, "op1", f[12], op1_val);
            if (op2_val !== f[13]) report_mismatch(name, "op2", f[13], op2_val);
            if (dest_addr !== f[14][31:0])
                report_mismatch(name, "dest", f[14], 64'(dest_addr));
            if ({dest_is_mem, dest_is_seg, dest_is_reg} !== f[15][2:0])
                report_mismatch(name, "dest type", f[15], 64'({dest_is_mem, dest_is_seg, dest_is_reg}));
            if (ie_out !== f[16][0]) report_mismatch(name, "ie_out", f[16], 64'(ie_out));
            if (ie_type_out !== f[17][3:0])
                report_mismatch(name, "ie_type", f[17], 64'(ie_type_out));
            last_op1 = f[12];
            last_op2 = f[13];
            last_dest = f[14][31:0];
            last_type = f[15][2:0];
            last_ie = f[16][0];
            last_iet = f[17][3:0];
        end
        valid_in = 1'b0;
    endtask

    initial begin
        int fd;
        string kind;
        string name;
        string rest;
        logic [63:0] f [19];
        void'($urandom(32'hafd3));
        {rst, valid_in, fwd_stall, ie_in, tlb_wr, tlb_wr_valid, tlb_wr_rw, wb_valid} = 8'h80;
        {opsize, wb_size, mem_rw, dest_id, tlb_wr_index} = '0;
        {mem_addr, mem_addr_end, eip, wb_addr, seg_lim, tlb_wr_vpn, tlb_wr_pfn, seg} = '0;
        {reg1, reg2, reg3, reg4, imm, wb_data} = '0;
        op1_sel = OP_REG1;
        op2_sel = OP_REG1;
        dest_sel = DEST_NONE;
        ie_type_in = '0;
        deadline = 100;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        if (valid_out !== 1'b0 || stall !== 1'b0 || ie_out !== 1'b0) begin
            $display("Outputs not cleared after reset");
            other_errors++;
        end
        @(negedge clk);
        fd = $fopen("mem_stage_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file");
            other_errors++;
        end else begin
            while ($fscanf(fd, " %s", kind) == 1) begin
                deadline = $time + 4 * 20;
                if (kind.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else if (kind == "R") begin
                    void'($fscanf(fd, " %h %h %h %h %h %h %h", reg1, reg2, reg3, reg4, imm,
                        seg, eip));
                end else if (kind == "T") begin
                    void'($fscanf(fd, " %h %h %h %h %h", tlb_wr_index, tlb_wr_vpn, tlb_wr_pfn,
                        tlb_wr_valid, tlb_wr_rw));
                    tlb_wr = 1'b1;
                    idle_cycle();
                end else if (kind == "W") begin
                    void'($fscanf(fd, " %h %h %h", wb_addr, wb_data, wb_size));
                    wb_valid = 1'b1;
                    idle_cycle();
                end else if (kind == "I") begin
                    void'($fscanf(fd, " %s %h %h %h %h %h %h %h %h %h %h %h %h", name, f[0], f[1],
                        f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]));
                    void'($fscanf(fd, " %h %h %h %h %h %h %h", f[12], f[13], f[14], f[15], f[16],
                        f[17], f[18]));
                    if (f[18][0]) deadline = $time + 4 * 200;
                    run_instr(name, f);
                end else begin
                    $display("Unknown line kind %s in the test file", kind);
                    other_errors++;
                    void'($fgets(rest, fd));
                end
            end
            $fclose(fd);
        end
        fwd_stall = 1'b0;
        done = 1'b1;
        $display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Deadline moves forward with every line read.
    initial begin
        do @(posedge clk); while (!done && $time <= deadline);
        if (!done) begin
            $display("Timeout, the stage never accepted the current instruction");
            $display("Something failed");
            $finish;
        end
    end

endmodule

//--- mem_stage.sv
module mem_stage
    import mem_pkg::*;
#(
    parameter int TLB_ENTRIES = 8,
    parameter int MEM_WORDS   = 256
) (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           valid_in,
    input  logic                           fwd_stall,
    input  opsize_t                        opsize,
    input  addr_t                          mem_addr,
    input  addr_t                          mem_addr_end,
    input  mem_rw_t                        mem_rw,
    input  page_t                          seg_lim,
    input  data_t                          reg1,
    input  data_t                          reg2,
    input  data_t                          reg3,
    input  data_t                          reg4,
    input  data_t                          imm,
    input  seg_t                           seg,
    input  addr_t                          eip,
    input  op_sel_e                        op1_sel,
    input  op_sel_e                        op2_sel,
    input  dest_sel_e                      dest_sel,
    input  logic [2:0]                     dest_id,
    input  logic                           ie_in,
    input  ie_type_t                       ie_type_in,

    input  logic                           tlb_wr,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_wr_index,
    input  page_t                          tlb_wr_vpn,
    input  page_t                          tlb_wr_pfn,
    input  logic                           tlb_wr_valid,
    input  logic                           tlb_wr_rw,

    input  logic                           wb_valid,
    input  addr_t                          wb_addr,
    input  data_t                          wb_data,
    input  opsize_t                        wb_size,

    output logic                           valid_out,
    output logic                           stall,
    output data_t                          op1_val,
    output data_t                          op2_val,
    output addr_t                          dest_addr,
    output logic                           dest_is_reg,
    output logic                           dest_is_seg,
    output logic                           dest_is_mem,
    output logic                           ie_out,
    output ie_type_t                       ie_type_out
);

    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [TLB_ENTRIES-1:0] entry_rw;
    page_t                  entry_vpn [TLB_ENTRIES];
    page_t                  entry_pfn [TLB_ENTRIES];
    logic                   tlb_hit;
    logic                   tlb_writable;
    page_t                  tlb_pfn;
    logic                   load_go;
    logic                   load_busy;
    data_t                  load_data;
    logic                   advance;
    addr_t                  phys_addr;
    data_t                  op1_next;
    data_t                  op2_next;
    addr_t                  dest_addr_next;
    logic [2:0]             dest_type_next;
    logic                   ie_out_next;
    ie_type_t               ie_type_next;

    tlb_entries #(.TLB_ENTRIES(TLB_ENTRIES)) i_tlb_entries (
        .clk, .rst, .tlb_wr, .tlb_wr_index, .tlb_wr_vpn, .tlb_wr_pfn, .tlb_wr_valid,
        .tlb_wr_rw, .entry_valid, .entry_rw, .entry_vpn, .entry_pfn
    );

    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) i_tlb_lookup (
        .entry_valid, .entry_rw, .entry_vpn, .entry_pfn, .mem_addr,
        .tlb_hit, .tlb_writable, .tlb_pfn
    );

    fault_detect i_fault_detect (
        .valid_in, .ie_in, .ie_type_in, .mem_rw, .mem_addr_end, .seg_lim,
        .tlb_hit, .tlb_writable, .ie_out_next, .ie_type_next, .load_go
    );

    data_port #(.MEM_WORDS(MEM_WORDS)) i_data_port (
        .clk, .rst, .load_go, .advance, .phys_addr, .opsize,
        .wb_valid, .wb_addr, .wb_data, .wb_size, .load_busy, .load_data
    );

    operand_select i_operand_select (
        .reg1, .reg2, .reg3, .reg4, .seg, .imm, .eip, .load_data, .tlb_pfn, .mem_addr,
        .op1_sel, .op2_sel, .dest_sel, .dest_id, .phys_addr, .op1_next, .op2_next,
        .dest_addr_next, .dest_type_next
    );

    stage_reg i_stage_reg (
        .clk, .rst, .valid_in, .fwd_stall, .load_busy, .op1_next, .op2_next,
        .dest_addr_next, .dest_type_next, .ie_out_next, .ie_type_next,
        .advance, .stall, .valid_out, .op1_val, .op2_val, .dest_addr,
        .dest_is_reg, .dest_is_seg, .dest_is_mem, .ie_out, .ie_type_out
    );

endmodule

//--- stage_reg.sv
module stage_reg
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       valid_in,
    input  logic       fwd_stall,
    input  logic       load_busy,
    input  data_t      op1_next,
    input  data_t      op2_next,
    input  addr_t      dest_addr_next,
    input  logic [2:0] dest_type_next,
    input  logic       ie_out_next,
    input  ie_type_t   ie_type_next,

    output logic       advance,
    output logic       stall,
    output logic       valid_out,
    output data_t      op1_val,
    output data_t      op2_val,
    output addr_t      dest_addr,
    output logic       dest_is_reg,
    output logic       dest_is_seg,
    output logic       dest_is_mem,
    output logic       ie_out,
    output ie_type_t   ie_type_out
);

    assign stall   = fwd_stall || load_busy;
    assign advance = valid_in && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out   <= 1'b0;
            ie_out      <= 1'b0;
            ie_type_out <= '0;
        end else if (advance) begin
            valid_out   <= 1'b1;
            ie_out      <= ie_out_next;
            ie_type_out <= ie_type_next;
        end else if (!fwd_stall) begin
            valid_out   <= 1'b0;                 // Bubble.
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            op1_val   <= op1_next;
            op2_val   <= op2_next;
            dest_addr <= dest_addr_next;
            {dest_is_mem, dest_is_seg, dest_is_reg} <= dest_type_next;
        end
    end

endmodule

//--- operand_select.sv
module operand_select
    import mem_pkg::*;
(
    input  data_t      reg1,
    input  data_t      reg2,
    input  data_t      reg3,
    input  data_t      reg4,
    input  seg_t       seg,
    input  data_t      imm,
    input  addr_t      eip,
    input  data_t      load_data,
    input  page_t      tlb_pfn,
    input  addr_t      mem_addr,
    input  op_sel_e    op1_sel,
    input  op_sel_e    op2_sel,
    input  dest_sel_e  dest_sel,
    input  logic [2:0] dest_id,

    output addr_t      phys_addr,
    output data_t      op1_next,
    output data_t      op2_next,
    output addr_t      dest_addr_next,
    output logic [2:0] dest_type_next
);

    function automatic data_t pick(op_sel_e sel);
        case (sel)
            OP_REG1: pick = reg1;
            OP_REG2: pick = reg2;
            OP_REG3: pick = reg3;
            OP_REG4: pick = reg4;
            OP_SEG:  pick = {48'b0, seg};
            OP_MEM:  pick = load_data;
            OP_IMM:  pick = imm;
            OP_EIP:  pick = {32'b0, eip};
            default: pick = '0;
        endcase
    endfunction

    // Frame from the TLB, offset from the linear address.
    assign phys_addr = {tlb_pfn, mem_addr[PAGE_OFFSET_W-1:0]};

    assign op1_next = pick(op1_sel);
    assign op2_next = pick(op2_sel);

    // Type bits are {mem, seg, reg}.
    always_comb begin
        case (dest_sel)
            DEST_REG: begin
                dest_addr_next = {29'b0, dest_id};
                dest_type_next = 3'b001;
            end
            DEST_SEG: begin
                dest_addr_next = {29'b0, dest_id};
                dest_type_next = 3'b010;
            end
            DEST_MEM: begin
                dest_addr_next = phys_addr;
                dest_type_next = 3'b100;
            end
            default: begin
                dest_addr_next = '0;
                dest_type_next = 3'b000;
            end
        endcase
    end

endmodule

//--- data_port.sv
module data_port
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    load_go,
    input  logic    advance,
    input  addr_t   phys_addr,
    input  opsize_t opsize,

    input  logic    wb_valid,
    input  addr_t   wb_addr,
    input  data_t   wb_data,
    input  opsize_t wb_size,

    output logic    load_busy,
    output data_t   load_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t              mem [MEM_WORDS];
    load_state_e        state;
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   wb_idx;
    logic [7:0]         rd_lanes;
    logic [7:0]         wb_lanes;
    data_t              rd_mask;
    data_t              rd_shifted;
    data_t              wb_shifted;

    function automatic logic [7:0] size_lanes(opsize_t size);
        case (size)
            SIZE_BYTE:  size_lanes = 8'h01;
            SIZE_WORD:  size_lanes = 8'h03;
            SIZE_DWORD: size_lanes = 8'h0f;
            default:    size_lanes = 8'hff;
        endcase
    endfunction

    assign rd_idx = phys_addr[IDX_W+2:3];
    assign wb_idx = wb_addr[IDX_W+2:3];

    // Lanes past byte 7 fall off, accesses never cross a word.
    assign wb_lanes   = size_lanes(wb_size) << wb_addr[2:0];
    assign wb_shifted = wb_data << {wb_addr[2:0], 3'b000};

    always_comb begin
        rd_lanes = size_lanes(opsize);
        for (int b = 0; b < 8; b++) begin
            rd_mask[b*8 +: 8] = {8{rd_lanes[b]}};
        end
    end

    assign rd_shifted = mem[rd_idx] >> {phys_addr[2:0], 3'b000};

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            for (int b = 0; b < 8; b++) begin
                if (wb_lanes[b]) mem[wb_idx][b*8 +: 8] <= wb_shifted[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LD_IDLE;
        end else if (state == LD_IDLE && load_go) begin
            state <= LD_READ;
        end else if (state == LD_READ && advance) begin
            state <= LD_IDLE;                    // Held here under fwd_stall.
        end
    end

    always_ff @(posedge clk) begin
        if (state == LD_IDLE && load_go) load_data <= rd_shifted & rd_mask;
    end

    assign load_busy = (state == LD_IDLE) && load_go;

endmodule

//--- fault_detect.sv
module fault_detect
    import mem_pkg::*;
(
    input  logic     valid_in,
    input  logic     ie_in,
    input  ie_type_t ie_type_in,
    input  mem_rw_t  mem_rw,
    input  addr_t    mem_addr_end,
    input  page_t    seg_lim,
    input  logic     tlb_hit,
    input  logic     tlb_writable,

    output logic     ie_out_next,
    output ie_type_t ie_type_next,
    output logic     load_go
);

    logic is_access;
    logic seg_fault;
    logic page_fault;
    logic prot_fault;
    logic any_fault;

    assign is_access = |mem_rw;

    // Limit is a 20-bit value compared against the last byte touched.
    assign seg_fault  = is_access && (mem_addr_end > {12'b0, seg_lim});
    assign page_fault = is_access && !tlb_hit;
    assign prot_fault = mem_rw[RW_WRITE] && tlb_hit && !tlb_writable;
    assign any_fault  = seg_fault || page_fault || prot_fault;

    always_comb begin
        ie_type_next          = '0;
        ie_type_next[IE_PROT] = valid_in && (seg_fault || prot_fault);
        ie_type_next[IE_PAGE] = valid_in && page_fault;
        ie_type_next[3:2]     = valid_in ? ie_type_in[3:2] : 2'b00;  // From earlier stages.
    end

    assign ie_out_next = valid_in && (ie_in || any_fault);

    // Only clean reads go to the array.
    assign load_go = valid_in && mem_rw[RW_READ] && !any_fault;

endmodule

//--- tlb_lookup.sv
module tlb_lookup
    import mem_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  logic [TLB_ENTRIES-1:0] entry_valid,
    input  logic [TLB_ENTRIES-1:0] entry_rw,
    input  page_t                  entry_vpn [TLB_ENTRIES],
    input  page_t                  entry_pfn [TLB_ENTRIES],
    input  addr_t                  mem_addr,

    output logic                   tlb_hit,
    output logic                   tlb_writable,
    output page_t                  tlb_pfn
);

    page_t vpn;

    assign vpn = mem_addr[31:PAGE_OFFSET_W];

    // Scan from the top so the lowest matching entry is the one left standing.
    always_comb begin
        tlb_hit      = 1'b0;
        tlb_writable = 1'b0;
        tlb_pfn      = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_valid[i] && entry_vpn[i] == vpn) begin
                tlb_hit      = 1'b1;
                tlb_writable = entry_rw[i];
                tlb_pfn      = entry_pfn[i];
            end
        end
    end

endmodule

//--- tlb_entries.sv
module tlb_entries
    import mem_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           tlb_wr,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_wr_index,
    input  page_t                          tlb_wr_vpn,
    input  page_t                          tlb_wr_pfn,
    input  logic                           tlb_wr_valid,
    input  logic                           tlb_wr_rw,

    output logic [TLB_ENTRIES-1:0]         entry_valid,
    output logic [TLB_ENTRIES-1:0]         entry_rw,
    output page_t                          entry_vpn [TLB_ENTRIES],
    output page_t                          entry_pfn [TLB_ENTRIES]
);

    // Valid bits are the only state that must start known.
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (tlb_wr) begin
            entry_valid[tlb_wr_index] <= tlb_wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr) begin
            entry_rw[tlb_wr_index]  <= tlb_wr_rw;   // 1 means writable.
            entry_vpn[tlb_wr_index] <= tlb_wr_vpn;
            entry_pfn[tlb_wr_index] <= tlb_wr_pfn;
        end
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] addr_t;    // Linear or physical address.
    typedef logic [63:0] data_t;    // Operand or memory word.
    typedef logic [19:0] page_t;    // Page number or frame.
    typedef logic [15:0] seg_t;
    typedef logic [1:0]  opsize_t;
    typedef logic [1:0]  mem_rw_t;
    typedef logic [3:0]  ie_type_t;

    // Access sizes.
    localparam opsize_t SIZE_BYTE  = 2'd0;
    localparam opsize_t SIZE_WORD  = 2'd1;
    localparam opsize_t SIZE_DWORD = 2'd2;
    localparam opsize_t SIZE_QWORD = 2'd3;

    localparam int RW_READ  = 0;    // Bit positions in mem_rw_t.
    localparam int RW_WRITE = 1;

    localparam int IE_PROT = 0;     // Bit positions in ie_type_t.
    localparam int IE_PAGE = 1;

    localparam int PAGE_OFFSET_W = 12;

    typedef enum logic [2:0] {
        OP_REG1 = 3'd0,
        OP_REG2 = 3'd1,
        OP_REG3 = 3'd2,
        OP_REG4 = 3'd3,
        OP_SEG  = 3'd4,
        OP_MEM  = 3'd5,
        OP_IMM  = 3'd6,
        OP_EIP  = 3'd7
    } op_sel_e;

    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_SEG  = 2'd2,
        DEST_MEM  = 2'd3
    } dest_sel_e;

    typedef enum logic {
        LD_IDLE = 1'b0,
        LD_READ = 1'b1
    } load_state_e;

endpackage
